// ==== exec_pkg.sv ====
/*
 * Shared types for the RV32 execute stage.
 * Only XLEN = 32 is supported. The struct layouts are fixed to this
 * width and every module parameter XLEN must be set to the same value.
 */
package exec_pkg;

    // --------------------------------------------------
    // Widths

    localparam int XLEN       = 32;   // Data and address width
    localparam int REG_ADDR_W = 5;    // Register index width

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;   // Register index

    // --------------------------------------------------
    // Operation encodings

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        CFU_NONE,                       // Not a control flow instruction
        CFU_BEQ,
        CFU_BNE,
        CFU_BLT,
        CFU_BGE,
        CFU_BLTU,
        CFU_BGEU,
        CFU_JAL,
        CFU_JALR
    } cfu_op_e;

    typedef enum logic [1:0] {
        LSU_NONE,
        LSU_LOAD,
        LSU_STORE
    } lsu_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } lsu_size_e;

    typedef enum logic [1:0] {
        WB_NONE,                        // No register write
        WB_ALU,                         // ALU result
        WB_NPC,                         // Link address
        WB_LSU                          // Loaded data
    } wb_sel_e;

    // Standard mcause codes
    typedef enum logic [3:0] {
        CAUSE_INSTR_MISALIGN = 4'd0,
        CAUSE_LOAD_MISALIGN  = 4'd4,
        CAUSE_STORE_MISALIGN = 4'd6
    } trap_cause_e;

    // --------------------------------------------------
    // Pipeline records

    typedef struct packed {
        logic [XLEN-1:0] pc;            // Current PC
        logic [XLEN-1:0] npc;           // Next sequential PC
        reg_addr_t       rd;            // Destination register
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;           // Sign extended immediate
        logic [XLEN-1:0] alu_lhs;       // ALU operands, also branch compare
        logic [XLEN-1:0] alu_rhs;
        alu_op_e         alu_op;
        cfu_op_e         cfu_op;
        lsu_op_e         lsu_op;
        lsu_size_e       lsu_size;
        logic            lsu_sext;      // Sign extend loaded value
        wb_sel_e         wb_sel;
    } ex_instr_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        reg_addr_t       rd;
        logic [XLEN-1:0] wdata;         // Result or store address
        logic            trap;
        trap_cause_e     trap_cause;    // Valid only with trap
        wb_sel_e         wb_sel;
    } wb_rec_t;

endpackage

// ==== exec_alu.sv ====
/*
 * Combinational integer ALU. One shared adder feeds add, sub and the
 * load/store address. Shift amounts use the low log2(XLEN) bits of rhs.
 */
module exec_alu import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0] lhs,        // Left operand
    input  logic [XLEN-1:0] rhs,        // Right operand
    input  alu_op_e         op,
    output logic [XLEN-1:0] sum,        // Adder output, lhs +/- rhs
    output logic            cmp_eq,     // lhs == rhs
    output logic            cmp_lt,     // Signed less than
    output logic            cmp_ltu,    // Unsigned less than
    output logic [XLEN-1:0] result
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic            sub;               // Subtract select
    logic [XLEN-1:0] add_rhs;           // Possibly inverted rhs
    logic [SHAMT_W-1:0] shamt;

    // --------------------------------------------------
    // Adder and compares

    assign sub     = (op == ALU_SUB);
    assign add_rhs = sub ? ~rhs : rhs;
    assign sum     = lhs + add_rhs + {{(XLEN-1){1'b0}}, sub};   // Two's complement sub

    assign cmp_eq  = (lhs == rhs);
    assign cmp_lt  = ($signed(lhs) < $signed(rhs));
    assign cmp_ltu = (lhs < rhs);

    assign shamt   = rhs[SHAMT_W-1:0];

    // --------------------------------------------------
    // Result select

    always_comb begin
        case (op)
            ALU_ADD,
            ALU_SUB:  result = sum;
            ALU_AND:  result = lhs & rhs;
            ALU_OR:   result = lhs | rhs;
            ALU_XOR:  result = lhs ^ rhs;
            ALU_SLL:  result = lhs << shamt;
            ALU_SRL:  result = lhs >> shamt;
            ALU_SRA:  result = $unsigned($signed(lhs) >>> shamt);   // Keeps sign
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, cmp_lt};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, cmp_ltu};
            default:  result = sum;
        endcase
    end

endmodule

// ==== exec_cfu.sv ====
/*
 * Control flow unit. Branch compares come from the ALU operands.
 * A taken target with bit 1 set traps and is never offered to fetch.
 * cf_valid holds with a stable target until cf_ack. A done flag keeps
 * one redirect per instruction while the stage stalls.
 */
module exec_cfu import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            valid,          // Decode holds an instruction
    input  logic            new_instr,      // Instruction accepted this cycle
    input  logic            flush,
    input  ex_instr_t       instr,
    input  logic            cmp_eq,         // From the ALU
    input  logic            cmp_lt,
    input  logic            cmp_ltu,
    output logic            cf_valid,       // Redirect request to fetch
    output logic [XLEN-1:0] cf_target,
    input  logic            cf_ack,
    output logic            taken,          // Aligned change of flow
    output logic            trap,           // Misaligned target
    output logic            finished
);

    logic            cond;                  // Branch condition met
    logic            is_jalr;
    logic [XLEN-1:0] base;                  // PC or rs1
    logic [XLEN-1:0] raw_target;
    logic [XLEN-1:0] target;
    logic            misalign;
    logic            done;                  // Redirect already acked

    // --------------------------------------------------
    // Branch decision

    always_comb begin
        case (instr.cfu_op)
            CFU_BEQ:  cond = cmp_eq;
            CFU_BNE:  cond = !cmp_eq;
            CFU_BLT:  cond = cmp_lt;
            CFU_BGE:  cond = !cmp_lt;
            CFU_BLTU: cond = cmp_ltu;
            CFU_BGEU: cond = !cmp_ltu;
            CFU_JAL,
            CFU_JALR: cond = 1'b1;          // Jumps always change flow
            default:  cond = 1'b0;          // CFU_NONE
        endcase
    end

    // --------------------------------------------------
    // Target calculation

    assign is_jalr    = (instr.cfu_op == CFU_JALR);
    assign base       = is_jalr ? instr.rs1_data : instr.pc;
    assign raw_target = base + instr.imm;
    assign target     = {raw_target[XLEN-1:1], raw_target[0] & !is_jalr};   // jalr clears bit 0
    assign misalign   = target[1];          // No compressed support

    assign trap       = valid && cond && misalign;
    assign taken      = valid && cond && !misalign;

    // --------------------------------------------------
    // Fetch redirect handshake

    assign cf_valid   = taken && !done;
    assign cf_target  = target;
    assign finished   = !taken || done || cf_ack;   // Done in ack cycle

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush || new_instr) begin
            done <= 1'b0;
        end else if (cf_valid && cf_ack) begin
            done <= 1'b1;                   // Hold until the stage moves on
        end
    end

endmodule

// ==== exec_lsu.sv ====
/*
 * Load/store unit on a req/gnt memory port, XLEN = 32 only.
 * Misaligned half and word accesses trap and make no request.
 * Read data is taken in the grant cycle, forwarded in that cycle and
 * held in a register while the stage stalls. A done flag keeps one
 * request per instruction.
 */
module exec_lsu import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic            valid,          // Decode holds an instruction
    input  logic            new_instr,      // Instruction accepted this cycle
    input  logic            flush,
    input  logic [XLEN-1:0] addr,           // Effective address from ALU
    input  ex_instr_t       instr,
    output logic            ready,          // Access complete or none needed
    output logic            trap,           // Misaligned address
    output logic [XLEN-1:0] load_data,      // Extended load result
    output logic            dmem_req,
    output logic [XLEN-1:0] dmem_addr,
    output logic            dmem_wen,
    output logic [3:0]      dmem_strb,
    output logic [XLEN-1:0] dmem_wdata,
    input  logic            dmem_gnt,
    input  logic [XLEN-1:0] dmem_rdata
);

    logic            access;                // Load or store present
    logic            is_store;
    logic            misalign;
    logic            grant;                 // Request accepted this cycle
    logic            done;                  // Access already granted
    logic [1:0]      lane;                  // Byte offset in the word
    logic [XLEN-1:0] rd_shift;              // Read data moved to lane 0
    logic [XLEN-1:0] rd_ext;
    logic [XLEN-1:0] load_q;                // Held result during stall

    assign access   = valid && (instr.lsu_op != LSU_NONE);
    assign is_store = (instr.lsu_op == LSU_STORE);
    assign lane     = addr[1:0];

    // --------------------------------------------------
    // Alignment check

    always_comb begin
        case (instr.lsu_size)
            SIZE_HALF: misalign = addr[0];
            SIZE_WORD: misalign = (addr[1:0] != 2'b00);
            default:   misalign = 1'b0;     // Bytes never misalign
        endcase
    end

    assign trap  = access && misalign;
    assign grant = dmem_req && dmem_gnt;
    assign ready = !access || misalign || done || grant;

    // --------------------------------------------------
    // Request side

    assign dmem_req  = access && !misalign && !done;
    assign dmem_addr = addr;                // Byte address, lanes via strobe
    assign dmem_wen  = is_store;

    always_comb begin
        case (instr.lsu_size)
            SIZE_BYTE: begin
                dmem_strb  = 4'b0001 << lane;
                dmem_wdata = {{(XLEN-8){1'b0}}, instr.rs2_data[7:0]} << {lane, 3'b000};
            end
            SIZE_HALF: begin
                dmem_strb  = 4'b0011 << {lane[1], 1'b0};
                dmem_wdata = {{(XLEN-16){1'b0}}, instr.rs2_data[15:0]} << {lane[1], 4'b0000};
            end
            default: begin                  // Whole word
                dmem_strb  = 4'b1111;
                dmem_wdata = instr.rs2_data;
            end
        endcase
    end

    // --------------------------------------------------
    // Load data extract and extend

    assign rd_shift = dmem_rdata >> {lane, 3'b000};

    always_comb begin
        case (instr.lsu_size)
            SIZE_BYTE: rd_ext = {{(XLEN-8){instr.lsu_sext & rd_shift[7]}}, rd_shift[7:0]};
            SIZE_HALF: rd_ext = {{(XLEN-16){instr.lsu_sext & rd_shift[15]}}, rd_shift[15:0]};
            default:   rd_ext = rd_shift;
        endcase
    end

    assign load_data = done ? load_q : rd_ext;   // Forward in grant cycle

    always_ff @(posedge g_clk) begin
        if (grant && !is_store) begin
            load_q <= rd_ext;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush || new_instr) begin
            done <= 1'b0;
        end else if (grant) begin
            done <= 1'b1;                   // No second request while stalled
        end
    end

endmodule

// ==== exec_stage.sv ====
/*
 * Execute stage top. Takes one decoded instruction per s2 handshake and
 * hands one writeback record over the s3 handshake. ALU work completes in
 * the same cycle; redirects and memory accesses stretch the stage.
 * XLEN is passed to every unit and must equal the package XLEN.
 */
module exec_stage import exec_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            g_clk,
    input  logic            g_resetn,

    input  logic            s2_valid,       // Decode has an instruction
    output logic            s2_ready,       // Instruction accepted
    input  ex_instr_t       s2_instr,
    input  logic            s2_flush,       // Level, clears stage state

    output logic            s3_valid,       // Record ready for writeback
    input  logic            s3_ready,
    output wb_rec_t         s3,             // Last record taken
    output logic            s3_full,

    output logic            cf_valid,       // Fetch redirect
    input  logic            cf_ack,
    output logic [XLEN-1:0] cf_target,

    output logic            dmem_req,
    output logic [XLEN-1:0] dmem_addr,
    output logic            dmem_wen,
    output logic [3:0]      dmem_strb,
    output logic [XLEN-1:0] dmem_wdata,
    input  logic            dmem_gnt,
    input  logic [XLEN-1:0] dmem_rdata
);

    logic            new_instr;             // s2 handshake this cycle
    logic            take;                  // s3 handshake this cycle

    logic [XLEN-1:0] alu_sum;
    logic            alu_cmp_eq;
    logic            alu_cmp_lt;
    logic            alu_cmp_ltu;
    logic [XLEN-1:0] alu_result;

    logic            cfu_taken;
    logic            cfu_trap;
    logic            cfu_finished;
    logic            cf_pending;            // Redirect not yet acked

    logic            lsu_ready;
    logic            lsu_trap;
    logic [XLEN-1:0] lsu_load_data;

    wb_rec_t         n_s3;                  // Next writeback record

    // --------------------------------------------------
    // Stage handshakes

    assign cf_pending = cfu_taken && !cfu_finished;
    assign s3_valid   = s2_valid && !cf_pending && lsu_ready;
    assign s2_ready   = s3_valid && s3_ready;
    assign new_instr  = s2_valid && s2_ready;
    assign take       = s3_valid && s3_ready;

    // --------------------------------------------------
    // Writeback record

    always_comb begin
        n_s3.pc     = s2_instr.pc;
        n_s3.rd     = s2_instr.rd;
        n_s3.wb_sel = s2_instr.wb_sel;
        n_s3.trap   = cfu_trap || lsu_trap;

        case (s2_instr.wb_sel)
            WB_ALU:  n_s3.wdata = alu_result;
            WB_NPC:  n_s3.wdata = s2_instr.npc;   // Link value
            WB_LSU:  n_s3.wdata = lsu_load_data;
            default: n_s3.wdata = (s2_instr.lsu_op == LSU_STORE) ? alu_sum : '0;
        endcase

        // CFU trap wins over LSU trap
        if (cfu_trap) begin
            n_s3.trap_cause = CAUSE_INSTR_MISALIGN;
        end else if (s2_instr.lsu_op == LSU_STORE) begin
            n_s3.trap_cause = CAUSE_STORE_MISALIGN;
        end else begin
            n_s3.trap_cause = CAUSE_LOAD_MISALIGN;   // Ignored unless trap set
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn || s2_flush) begin
            s3_full <= 1'b0;
        end else if (s3_ready) begin
            s3_full <= s3_valid;            // Empties on a take without a record
        end
    end

    always_ff @(posedge g_clk) begin
        if (take) begin
            s3 <= n_s3;                     // Payload only
        end
    end

    // --------------------------------------------------
    // Units

    exec_alu #(
        .XLEN       (XLEN)
    ) alu0 (
        .lhs        (s2_instr.alu_lhs),
        .rhs        (s2_instr.alu_rhs),
        .op         (s2_instr.alu_op),
        .sum        (alu_sum),
        .cmp_eq     (alu_cmp_eq),
        .cmp_lt     (alu_cmp_lt),
        .cmp_ltu    (alu_cmp_ltu),
        .result     (alu_result)
    );

    exec_cfu #(
        .XLEN       (XLEN)
    ) cfu0 (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .valid      (s2_valid),
        .new_instr  (new_instr),
        .flush      (s2_flush),
        .instr      (s2_instr),
        .cmp_eq     (alu_cmp_eq),
        .cmp_lt     (alu_cmp_lt),
        .cmp_ltu    (alu_cmp_ltu),
        .cf_valid   (cf_valid),
        .cf_target  (cf_target),
        .cf_ack     (cf_ack),
        .taken      (cfu_taken),
        .trap       (cfu_trap),
        .finished   (cfu_finished)
    );

    exec_lsu #(
        .XLEN       (XLEN)
    ) lsu0 (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .valid      (s2_valid),
        .new_instr  (new_instr),
        .flush      (s2_flush),
        .addr       (alu_sum),              // rs1 + imm from the adder
        .instr      (s2_instr),
        .ready      (lsu_ready),
        .trap       (lsu_trap),
        .load_data  (lsu_load_data),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_wen   (dmem_wen),
        .dmem_strb  (dmem_strb),
        .dmem_wdata (dmem_wdata),
        .dmem_gnt   (dmem_gnt),
        .dmem_rdata (dmem_rdata)
    );

endmodule

// ==== tb_clkgen.sv ====
/*
 * Testbench clock and reset source.
 * Reset is held low for RESET_CYCLES rising edges and is released
 * 1 time unit after the last one, like every other testbench input.
 */
module tb_clkgen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk = 1'b0;
        forever #(PERIOD / 2) g_clk = ~g_clk;
    end

    initial begin
        g_resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;                // Synchronous release
    end

endmodule

// ==== tb_exec_stage.sv ====
/*
 * Random testbench for the execute stage. Inputs change 1 unit after the
 * rising edge and outputs are sampled at the falling edge.
 * Load/store bases stay inside the 1 KiB memory model.
 * Stops at the first mismatch.
 */
module tb_exec_stage import exec_pkg::*;;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 300;
    localparam int MEM_WORDS    = 256;
    localparam int TIMEOUT      = (NUM_INSTR * 20 + RESET_CYCLES) * PERIOD;

    typedef struct packed {
        wb_rec_t     rec;                   // Expected writeback record
        logic        redirect;              // One redirect to fetch
        logic [31:0] target;
        logic        mem_req;               // One memory request
        logic [31:0] mem_addr;
        logic        mem_wen;
        logic [3:0]  mem_strb;
        logic [31:0] mem_wdata;
    } expect_t;

    logic        g_clk, g_resetn;
    logic        s2_valid, s2_ready, s2_flush;
    ex_instr_t   s2_instr;
    logic        s3_valid, s3_ready, s3_full;
    wb_rec_t     s3;
    logic        cf_valid, cf_ack;
    logic [31:0] cf_target;
    logic        dmem_req, dmem_wen, dmem_gnt;
    logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
    logic [3:0]  dmem_strb;

    logic [31:0] mem [0:MEM_WORDS-1];       // Data memory model
    int          seed = 71461;
    expect_t     exp_q[$];                  // One entry per instruction in flight
    expect_t     cmp_exp;                   // Record taken on the last edge
    logic        cmp_pending = 1'b0;
    logic        full_exp = 1'b0;           // Expected s3_full after the edge
    int          cf_seen = 0;               // Redirects acked for current instr
    int          mem_seen = 0;              // Grants for current instr

    assign dmem_rdata = mem[dmem_addr[9:2]];   // Read data in the grant cycle

    tb_clkgen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) clkgen0 (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    exec_stage #(.XLEN(32)) dut0 (.*);

    // --------------------------------------------------
    // Reporting

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
            $display("Result: FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Stopped on testbench error");
    endtask

    // --------------------------------------------------
    // Reference model

    function automatic expect_t predict(input ex_instr_t ins, input logic [31:0] word);
        expect_t     e;
        logic [31:0] a, b, ea, alu_res, lval;
        logic [4:0]  sh;
        logic        cond, cf_trap, ls_trap, store;
        e = '0;
        a = ins.alu_lhs;
        b = ins.alu_rhs;
        case (ins.alu_op)
            ALU_SUB:  alu_res = a - b;
            ALU_AND:  alu_res = a & b;
            ALU_OR:   alu_res = a | b;
            ALU_XOR:  alu_res = a ^ b;
            ALU_SLL:  alu_res = a << b[4:0];
            ALU_SRL:  alu_res = a >> b[4:0];
            ALU_SRA:  alu_res = $signed(a) >>> b[4:0];
            ALU_SLT:  alu_res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: alu_res = (a < b) ? 32'd1 : 32'd0;
            default:  alu_res = a + b;
        endcase
        case (ins.cfu_op)
            CFU_BEQ:  cond = (a == b);
            CFU_BNE:  cond = (a != b);
            CFU_BLT:  cond = ($signed(a) < $signed(b));
            CFU_BGE:  cond = ($signed(a) >= $signed(b));
            CFU_BLTU: cond = (a < b);
            CFU_BGEU: cond = (a >= b);
            CFU_JAL, CFU_JALR: cond = 1'b1;
            default:  cond = 1'b0;
        endcase
        if (ins.cfu_op == CFU_JALR) begin
            e.target = (ins.rs1_data + ins.imm) & 32'hffff_fffe;
        end else begin
            e.target = ins.pc + ins.imm;
        end
        cf_trap    = cond && e.target[1];  // Only 4-byte aligned targets
        e.redirect = cond && !e.target[1];

        // Memory side, address is rs1 plus imm
        store = (ins.lsu_op == LSU_STORE);
        ea    = ins.alu_lhs + ins.imm;
        sh    = {ea[1:0], 3'b000};
        case (ins.lsu_size)
            SIZE_HALF: ls_trap = ea[0];
            SIZE_WORD: ls_trap = (ea[1:0] != 2'b00);
            default:   ls_trap = 1'b0;
        endcase
        ls_trap      = ls_trap && (ins.lsu_op != LSU_NONE);
        e.mem_req    = (ins.lsu_op != LSU_NONE) && !ls_trap;
        e.mem_addr   = ea;
        e.mem_wen    = store;
        lval         = word >> sh;
        case (ins.lsu_size)
            SIZE_BYTE: begin
                e.mem_strb  = 4'b0001 << ea[1:0];
                e.mem_wdata = {24'h0, ins.rs2_data[7:0]} << sh;
                lval = {{24{ins.lsu_sext & lval[7]}}, lval[7:0]};
            end
            SIZE_HALF: begin
                e.mem_strb  = 4'b0011 << ea[1:0];
                e.mem_wdata = {16'h0, ins.rs2_data[15:0]} << sh;
                lval = {{16{ins.lsu_sext & lval[15]}}, lval[15:0]};
            end
            default: begin
                e.mem_strb  = 4'b1111;
                e.mem_wdata = ins.rs2_data;
            end
        endcase

        e.rec.pc     = ins.pc;
        e.rec.rd     = ins.rd;
        e.rec.wb_sel = ins.wb_sel;
        e.rec.trap   = cf_trap || ls_trap;
        e.rec.trap_cause = cf_trap ? CAUSE_INSTR_MISALIGN :
                           (store ? CAUSE_STORE_MISALIGN : CAUSE_LOAD_MISALIGN);
        case (ins.wb_sel)
            WB_ALU:  e.rec.wdata = alu_res;
            WB_NPC:  e.rec.wdata = ins.npc;
            WB_LSU:  e.rec.wdata = lval;
            default: e.rec.wdata = store ? ea : 32'h0;   // Stores report the address
        endcase
        return e;
    endfunction

    // --------------------------------------------------
    // Stimulus

    task automatic gen_instr(output ex_instr_t ins);
        int kind;
        ins          = '0;
        kind         = {$random(seed)} % 4;
        ins.pc       = $random(seed) & 32'h0000_fffc;
        ins.npc      = ins.pc + 32'd4;
        ins.rd       = 5'($random(seed));
        ins.rs1_data = $random(seed);
        ins.rs2_data = $random(seed);
        ins.imm      = ($random(seed) % 64) * 2;          // Even, bit 1 random
        ins.alu_lhs  = ins.rs1_data;
        ins.alu_rhs  = (($random(seed) % 4) == 0) ? ins.rs1_data : ins.rs2_data;
        case (kind)
            0: begin                        // ALU
                ins.alu_op = alu_op_e'(4'({$random(seed)} % 10));
                ins.wb_sel = WB_ALU;
            end
            1: begin                        // Conditional branch
                ins.cfu_op = cfu_op_e'(4'(1 + {$random(seed)} % 6));
            end
            2: begin                        // Jump and link
                ins.cfu_op = (($random(seed) % 2) == 0) ? CFU_JAL : CFU_JALR;
                ins.wb_sel = WB_NPC;
            end
            default: begin                  // Load or store, some misaligned
                ins.lsu_op   = (($random(seed) % 2) == 0) ? LSU_LOAD : LSU_STORE;
                ins.lsu_size = lsu_size_e'(2'({$random(seed)} % 3));
                ins.lsu_sext = 1'($random(seed));
                ins.rs1_data = ({$random(seed)} % 250) * 4;
                ins.imm      = {$random(seed)} % 8;
                ins.alu_lhs  = ins.rs1_data;
                ins.alu_rhs  = ins.imm;
                ins.wb_sel   = (ins.lsu_op == LSU_LOAD) ? WB_LSU : WB_NONE;
            end
        endcase
    endtask

    initial begin : stimulus
        ex_instr_t   ins;
        logic [31:0] ea;
        logic        do_flush, accepted;
        s2_valid = 1'b0;
        s2_instr = '0;
        s2_flush = 1'b0;
        wait (g_resetn === 1'b1);
        @(negedge g_clk);
        check_value("s3_full", 32'(s3_full), 0);
        check_value("cf_valid", 32'(cf_valid), 0);
        check_value("dmem_req", 32'(dmem_req), 0);
        @(posedge g_clk);
        #1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            gen_instr(ins);
            ea = ins.alu_lhs + ins.imm;
            exp_q.push_back(predict(ins, mem[ea[9:2]]));
            do_flush = ({$random(seed)} % 12) == 0;
            s2_instr = ins;
            s2_valid = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge g_clk);
                if (s2_ready) begin
                    accepted = 1'b1;
                end else if (do_flush) begin
                    do_flush = 1'b0;        // One flush cycle, then resend
                    @(posedge g_clk);
                    #1;
                    s2_valid = 1'b0;
                    s2_flush = 1'b1;
                    @(posedge g_clk);
                    #1;
                    s2_flush = 1'b0;
                    s2_valid = 1'b1;
                end
            end
            @(posedge g_clk);
            #1;
        end
        s2_valid = 1'b0;
        while (exp_q.size() != 0 || cmp_pending) @(negedge g_clk);
        @(negedge g_clk);
        $display("Result: PASSED");
        $finish;
    end

    // --------------------------------------------------
    // Memory, fetch and writeback responders

    initial begin : responders
        int   gnt_wait, ack_wait;
        logic next_ready;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h9e37_79b9 * (i + 1);   // Odd multiplier, all address bits count
        end
        gnt_wait = 0;
        ack_wait = 0;
        dmem_gnt = 1'b0;
        cf_ack   = 1'b0;
        s3_ready = 1'b0;
        forever begin
            @(negedge g_clk);
            if (dmem_req && dmem_gnt) begin
                for (int b = 0; b < 4; b++) begin
                    if (dmem_wen && dmem_strb[b]) begin
                        mem[dmem_addr[9:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
                    end
                end
                gnt_wait = {$random(seed)} % 4;
            end else if (dmem_req && gnt_wait > 0) begin
                gnt_wait--;
            end
            if (cf_valid && cf_ack) begin
                ack_wait = {$random(seed)} % 3;
            end else if (cf_valid && ack_wait > 0) begin
                ack_wait--;
            end
            next_ready = ($random(seed) % 3) != 0;
            @(posedge g_clk);
            #1;
            dmem_gnt = (gnt_wait == 0);
            cf_ack   = (ack_wait == 0);
            s3_ready = next_ready;
        end
    end

    // --------------------------------------------------
    // Compare process

    always @(negedge g_clk) begin : compare_proc
        expect_t cur;
        if (g_resetn) begin
            check_value("s3_full", 32'(s3_full), 32'(full_exp));
            if (cmp_pending) begin
                check_value("s3.pc", s3.pc, cmp_exp.rec.pc);
                check_value("s3.rd", 32'(s3.rd), 32'(cmp_exp.rec.rd));
                check_value("s3.wb_sel", 32'(s3.wb_sel), 32'(cmp_exp.rec.wb_sel));
                check_value("s3.trap", 32'(s3.trap), 32'(cmp_exp.rec.trap));
                if (cmp_exp.rec.trap) begin
                    check_value("s3.trap_cause", 32'(s3.trap_cause), 32'(cmp_exp.rec.trap_cause));
                end else begin
                    check_value("s3.wdata", s3.wdata, cmp_exp.rec.wdata);
                end
                cmp_pending = 1'b0;
            end
            if (s2_flush) begin
                cf_seen        = 0;         // Flushed work is issued again
                mem_seen       = 0;
            end else if (cf_valid || dmem_req || s3_valid) begin
                if (exp_q.size() == 0) begin
                    report_failure("DUT output active with no instruction sent");
                end
                cur = exp_q[0];
                if (cf_valid) begin
                    check_value("cf_valid", 32'(cf_valid), 32'(cur.redirect));
                    check_value("cf_target", cf_target, cur.target);
                    if (cf_ack) begin
                        check_value("redirects before ack", cf_seen, 0);
                        cf_seen++;
                    end
                end
                if (dmem_req) begin
                    check_value("dmem_req", 32'(dmem_req), 32'(cur.mem_req));
                    check_value("dmem_addr", dmem_addr, cur.mem_addr);
                    check_value("dmem_wen", 32'(dmem_wen), 32'(cur.mem_wen));
                    check_value("dmem_strb", 32'(dmem_strb), 32'(cur.mem_strb));
                    if (cur.mem_wen) begin
                        check_value("dmem_wdata", dmem_wdata, cur.mem_wdata);
                    end
                    if (dmem_gnt) begin
                        check_value("grants before this one", mem_seen, 0);
                        mem_seen++;
                    end
                end
                if (s3_valid && s3_ready) begin
                    cur = exp_q.pop_front();
                    check_value("redirect count", cf_seen, 32'(cur.redirect));
                    check_value("memory access count", mem_seen, 32'(cur.mem_req));
                    cmp_exp     = cur;
                    cmp_pending = 1'b1;     // Record is visible after the edge
                    cf_seen     = 0;
                    mem_seen    = 0;
                end
            end

            // Writeback register occupancy after this edge
            if (s2_flush) begin
                full_exp = 1'b0;
            end else if (s3_ready) begin
                full_exp = s3_valid;        // Take fills, empty take drains
            end
        end
    end

    // --------------------------------------------------
    // Watchdog

    initial begin : watchdog
        #(TIMEOUT);
        $display("Timeout: the stage stopped accepting instructions");
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== exec_stage.f ====
exec_pkg.sv
exec_alu.sv
exec_cfu.sv
exec_lsu.sv
exec_stage.sv
tb_clkgen.sv
tb_exec_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it.
# Exit status is 1 when the log holds the failure line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_exec_stage -f exec_stage.f \
    -o sim_exec_stage > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_exec_stage > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation done"
